//--- verilog/cgra_dma_consts.svh
`ifndef CGRA_DMA_CONSTS_SVH
`define CGRA_DMA_CONSTS_SVH

// --------------------
// Data path widths
// --------------------
`define DMA_WORD_W        64
`define DMA_MEM_DEPTH     256
`define DMA_WORD_AW       8
`define DMA_BEATS_PER_PKT 3
// Three 64-bit beats per packet
`define DMA_PKT_W         192
`define DMA_LEN_W         16

// --------------------
// APB address map, byte offsets
// --------------------
`define DMA_APB_AW        12
// Upper half of the 4 KB space maps onto the SRAM words
`define DMA_SRAM_BASE     12'h800
`define DMA_REG_CTRL      12'h000
`define DMA_REG_SRC       12'h008
`define DMA_REG_DST       12'h010
`define DMA_REG_LEN_RX    12'h018
`define DMA_REG_LEN_TX    12'h020
`define DMA_REG_STATUS    12'h028

`endif

//--- verilog/dma_mem_pkg.sv
`include "cgra_dma_consts.svh"

package dma_mem_pkg;

  // One SRAM word, also one packet beat
  typedef logic [`DMA_WORD_W-1:0] word_t;

  // Word index into the shared SRAM
  typedef logic [`DMA_WORD_AW-1:0] waddr_t;

  // Beat 0 sits in the low 64 bits
  typedef logic [`DMA_PKT_W-1:0] pkt_t;

  // Beat index within a packet
  typedef logic [$clog2(`DMA_BEATS_PER_PKT)-1:0] beat_t;

  // Word request, held by the requester until gnt
  typedef struct packed {
    logic   req;
    logic   we;
    waddr_t addr;
    word_t  wdata;
  } mem_req_t;

  // Grant and read data, both valid in the granted cycle
  typedef struct packed {
    logic  gnt;
    word_t rdata;
  } mem_rsp_t;

endpackage

//--- verilog/dma_ctrl_pkg.sv
`include "cgra_dma_consts.svh"

package dma_ctrl_pkg;

  // Byte address on the APB port
  typedef logic [`DMA_APB_AW-1:0] paddr_t;

  // Packet count
  typedef logic [`DMA_LEN_W-1:0] len_t;

  // --------------------
  // APB slave port
  // --------------------
  typedef struct packed {
    logic                psel;
    logic                penable;
    logic                pwrite;
    paddr_t              paddr;
    dma_mem_pkg::word_t  pwdata;
  } apb_req_t;

  typedef struct packed {
    logic                pready;
    dma_mem_pkg::word_t  prdata;
    logic                pslverr;
  } apb_rsp_t;

  // --------------------
  // DMA control and status
  // --------------------
  // Start bits are single-cycle pulses
  typedef struct packed {
    logic                 start_rx;
    logic                 start_tx;
    dma_mem_pkg::waddr_t  src;
    dma_mem_pkg::waddr_t  dst;
    len_t                 len_rx;
    len_t                 len_tx;
  } dma_cfg_t;

  // Same bit order as the STATUS register
  typedef struct packed {
    logic done_tx;
    logic busy_tx;
    logic done_rx;
    logic busy_rx;
  } dma_stat_t;

  typedef enum logic [1:0] {RX_IDLE, RX_READ, RX_OFFER} rx_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_CAPTURE, TX_WRITE} tx_state_e;

endpackage

//--- verilog/dma_reg_decode.sv
`timescale 1ns/1ns
`include "cgra_dma_consts.svh"

module dma_reg_decode (
  input  logic                   clk,
  input  logic                   rstn,
  input  dma_ctrl_pkg::apb_req_t apb_i,
  output dma_ctrl_pkg::apb_rsp_t apb_o,
  output dma_ctrl_pkg::dma_cfg_t cfg_o,
  input  dma_ctrl_pkg::dma_stat_t stat_i,
  output dma_mem_pkg::mem_req_t  mem_o,
  input  dma_mem_pkg::mem_rsp_t  mem_i
);

  logic                access;
  logic                wr_en;
  logic                rd_en;
  logic                in_sram;
  logic                reg_hit;
  logic                ctrl_wr;
  dma_mem_pkg::word_t  reg_rdata;
  dma_mem_pkg::waddr_t src_q;
  dma_mem_pkg::waddr_t dst_q;
  dma_ctrl_pkg::len_t  len_rx_q;
  dma_ctrl_pkg::len_t  len_tx_q;

  // Access phase of a two-phase transfer, never stretched
  assign access = apb_i.psel & apb_i.penable;
  assign wr_en  = access & apb_i.pwrite;
  assign rd_en  = access & ~apb_i.pwrite;

  // Everything from the window base upward is SRAM
  assign in_sram = (apb_i.paddr >= `DMA_SRAM_BASE);

  // --------------------
  // Register read mux and hit detect
  // --------------------
  always_comb begin
    reg_hit   = 1'b1;
    reg_rdata = '0;
    case (apb_i.paddr)
      // Start bits are pulses, so CTRL reads as zero
      `DMA_REG_CTRL:   reg_rdata = '0;
      `DMA_REG_SRC:    reg_rdata = dma_mem_pkg::word_t'(src_q);
      `DMA_REG_DST:    reg_rdata = dma_mem_pkg::word_t'(dst_q);
      `DMA_REG_LEN_RX: reg_rdata = dma_mem_pkg::word_t'(len_rx_q);
      `DMA_REG_LEN_TX: reg_rdata = dma_mem_pkg::word_t'(len_tx_q);
      `DMA_REG_STATUS: reg_rdata = dma_mem_pkg::word_t'(stat_i);
      default:         reg_hit = 1'b0;
    endcase
  end

  // Config registers, truncated to their widths
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      src_q    <= '0;
      dst_q    <= '0;
      len_rx_q <= '0;
      len_tx_q <= '0;
    end else if (wr_en && !in_sram) begin
      case (apb_i.paddr)
        `DMA_REG_SRC:    src_q    <= apb_i.pwdata[`DMA_WORD_AW-1:0];
        `DMA_REG_DST:    dst_q    <= apb_i.pwdata[`DMA_WORD_AW-1:0];
        `DMA_REG_LEN_RX: len_rx_q <= apb_i.pwdata[`DMA_LEN_W-1:0];
        `DMA_REG_LEN_TX: len_tx_q <= apb_i.pwdata[`DMA_LEN_W-1:0];
        default: ;
      endcase
    end
  end

  // Start pulses go out in the write cycle itself
  // so busy shows one edge later
  assign ctrl_wr        = wr_en && (apb_i.paddr == `DMA_REG_CTRL);
  assign cfg_o.start_rx = ctrl_wr & apb_i.pwdata[0];
  assign cfg_o.start_tx = ctrl_wr & apb_i.pwdata[1];
  assign cfg_o.src      = src_q;
  assign cfg_o.dst      = dst_q;
  assign cfg_o.len_rx   = len_rx_q;
  assign cfg_o.len_tx   = len_tx_q;

  // --------------------
  // SRAM window
  // --------------------
  // One-cycle request on the top-priority port, byte address to word index
  assign mem_o.req   = access & in_sram;
  assign mem_o.we    = apb_i.pwrite;
  assign mem_o.addr  = apb_i.paddr[`DMA_WORD_AW+2:3];
  assign mem_o.wdata = apb_i.pwdata;

  // Response, zero data on anything unmapped
  always_comb begin
    apb_o.pready  = access;
    apb_o.pslverr = access & ~(in_sram | reg_hit);
    apb_o.prdata  = '0;
    if (rd_en) begin
      if (in_sram && mem_i.gnt) begin
        apb_o.prdata = mem_i.rdata;
      end else if (reg_hit) begin
        apb_o.prdata = reg_rdata;
      end
    end
  end

  a_err_zero_data: assert property (
    @(posedge clk) disable iff (!rstn)
    apb_o.pslverr |-> (apb_o.prdata == '0)
  );

endmodule

//--- verilog/dma_rx_engine.sv
`timescale 1ns/1ns
`include "cgra_dma_consts.svh"

module dma_rx_engine (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   start_i,
  input  dma_mem_pkg::waddr_t    src_i,
  input  logic [`DMA_LEN_W-1:0]  len_i,
  output logic                   busy_o,
  output logic                   done_o,
  output dma_mem_pkg::mem_req_t  mem_o,
  input  dma_mem_pkg::mem_rsp_t  mem_i,
  output dma_mem_pkg::pkt_t      pkt_o,
  output logic                   pkt_valid_o,
  input  logic                   pkt_ready_i
);

  dma_ctrl_pkg::rx_state_e state_q;
  dma_mem_pkg::beat_t      beat_q;
  dma_mem_pkg::waddr_t     addr_q;
  dma_ctrl_pkg::len_t      pkts_left_q;
  logic                    done_q;
  dma_mem_pkg::pkt_t       pkt_q;
  logic                    rd_fire;
  logic                    last_beat;

  assign rd_fire   = (state_q == dma_ctrl_pkg::RX_READ) && mem_i.gnt;
  assign last_beat = (beat_q == dma_mem_pkg::beat_t'(`DMA_BEATS_PER_PKT - 1));

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q     <= dma_ctrl_pkg::RX_IDLE;
      beat_q      <= '0;
      addr_q      <= '0;
      pkts_left_q <= '0;
      done_q      <= 1'b0;
    end else begin
      case (state_q)
        dma_ctrl_pkg::RX_IDLE: begin
          // Done stays set until the next start
          if (start_i) begin
            done_q      <= (len_i == '0);
            pkts_left_q <= len_i;
            addr_q      <= src_i;
            beat_q      <= '0;
            if (len_i != '0) begin
              state_q <= dma_ctrl_pkg::RX_READ;
            end
          end
        end
        dma_ctrl_pkg::RX_READ: begin
          // Advance only on granted beats
          if (mem_i.gnt) begin
            addr_q <= addr_q + 1'b1;
            if (last_beat) begin
              beat_q  <= '0;
              state_q <= dma_ctrl_pkg::RX_OFFER;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        dma_ctrl_pkg::RX_OFFER: begin
          if (pkt_ready_i) begin
            if (pkts_left_q == dma_ctrl_pkg::len_t'(1)) begin
              done_q  <= 1'b1;
              state_q <= dma_ctrl_pkg::RX_IDLE;
            end else begin
              pkts_left_q <= pkts_left_q - 1'b1;
              state_q     <= dma_ctrl_pkg::RX_READ;
            end
          end
        end
        default: state_q <= dma_ctrl_pkg::RX_IDLE;
      endcase
    end
  end

  // Gather read beats into the packet
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      pkt_q[beat_q*`DMA_WORD_W +: `DMA_WORD_W] <= mem_i.rdata;
    end
  end

  // Read-only port
  assign mem_o.req   = (state_q == dma_ctrl_pkg::RX_READ);
  assign mem_o.we    = 1'b0;
  assign mem_o.addr  = addr_q;
  assign mem_o.wdata = '0;

  assign pkt_o       = pkt_q;
  assign pkt_valid_o = (state_q == dma_ctrl_pkg::RX_OFFER);
  assign busy_o      = (state_q != dma_ctrl_pkg::RX_IDLE);
  assign done_o      = done_q;

  a_offer_held: assert property (
    @(posedge clk) disable iff (!rstn)
    (pkt_valid_o && !pkt_ready_i) |=> (pkt_valid_o && $stable(pkt_o))
  );

endmodule

//--- verilog/dma_tx_engine.sv
`timescale 1ns/1ns
`include "cgra_dma_consts.svh"

module dma_tx_engine (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   start_i,
  input  dma_mem_pkg::waddr_t    dst_i,
  input  logic [`DMA_LEN_W-1:0]  len_i,
  output logic                   busy_o,
  output logic                   done_o,
  input  dma_mem_pkg::pkt_t      pkt_i,
  input  logic                   pkt_valid_i,
  output logic                   pkt_ready_o,
  output dma_mem_pkg::mem_req_t  mem_o,
  input  dma_mem_pkg::mem_rsp_t  mem_i
);

  dma_ctrl_pkg::tx_state_e state_q;
  dma_mem_pkg::beat_t      beat_q;
  dma_mem_pkg::waddr_t     addr_q;
  dma_ctrl_pkg::len_t      pkts_left_q;
  logic                    done_q;
  dma_mem_pkg::pkt_t       buf_q;
  logic                    capture;
  logic                    last_beat;

  // Accept upstream only while waiting for a packet
  assign pkt_ready_o = (state_q == dma_ctrl_pkg::TX_CAPTURE);
  assign capture     = pkt_ready_o & pkt_valid_i;
  assign last_beat   = (beat_q == dma_mem_pkg::beat_t'(`DMA_BEATS_PER_PKT - 1));

  // --------------------
  // Control FSM
  // --------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state_q     <= dma_ctrl_pkg::TX_IDLE;
      beat_q      <= '0;
      addr_q      <= '0;
      pkts_left_q <= '0;
      done_q      <= 1'b0;
    end else begin
      case (state_q)
        dma_ctrl_pkg::TX_IDLE: begin
          if (start_i) begin
            done_q      <= (len_i == '0);
            pkts_left_q <= len_i;
            addr_q      <= dst_i;
            if (len_i != '0) begin
              state_q <= dma_ctrl_pkg::TX_CAPTURE;
            end
          end
        end
        dma_ctrl_pkg::TX_CAPTURE: begin
          if (pkt_valid_i) begin
            beat_q  <= '0;
            state_q <= dma_ctrl_pkg::TX_WRITE;
          end
        end
        dma_ctrl_pkg::TX_WRITE: begin
          // Beats land at consecutive words across packets
          if (mem_i.gnt) begin
            addr_q <= addr_q + 1'b1;
            if (!last_beat) begin
              beat_q <= beat_q + 1'b1;
            end else if (pkts_left_q == dma_ctrl_pkg::len_t'(1)) begin
              done_q  <= 1'b1;
              state_q <= dma_ctrl_pkg::TX_IDLE;
            end else begin
              pkts_left_q <= pkts_left_q - 1'b1;
              state_q     <= dma_ctrl_pkg::TX_CAPTURE;
            end
          end
        end
        default: state_q <= dma_ctrl_pkg::TX_IDLE;
      endcase
    end
  end

  // One-packet holding buffer
  always_ff @(posedge clk) begin
    if (capture) begin
      buf_q <= pkt_i;
    end
  end

  // Write port, current beat out of the buffer
  assign mem_o.req   = (state_q == dma_ctrl_pkg::TX_WRITE);
  assign mem_o.we    = 1'b1;
  assign mem_o.addr  = addr_q;
  assign mem_o.wdata = buf_q[beat_q*`DMA_WORD_W +: `DMA_WORD_W];

  assign busy_o = (state_q != dma_ctrl_pkg::TX_IDLE);
  assign done_o = done_q;

endmodule

//--- verilog/pkt_loopback_buffer.sv
`timescale 1ns/1ns

module pkt_loopback_buffer (
  input  logic              clk,
  input  logic              rstn,
  input  dma_mem_pkg::pkt_t in_i,
  input  logic              in_valid_i,
  output logic              in_ready_o,
  output dma_mem_pkg::pkt_t out_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  localparam int DEPTH = 2;

  dma_mem_pkg::pkt_t mem_q [DEPTH];
  logic              wptr_q;
  logic              rptr_q;
  logic [1:0]        count_q;
  logic              push;
  logic              pop;

  // Accept while a slot is free, independent of pop
  assign in_ready_o  = (count_q < 2'(DEPTH));
  assign out_valid_o = (count_q != '0);
  assign out_o       = mem_q[rptr_q];
  assign push        = in_valid_i & in_ready_o;
  assign pop         = out_valid_o & out_ready_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wptr_q  <= 1'b0;
      rptr_q  <= 1'b0;
      count_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= ~wptr_q;
      end
      if (pop) begin
        rptr_q <= ~rptr_q;
      end
      // Simultaneous push and pop keeps the count
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wptr_q] <= in_i;
    end
  end

  a_count_max: assert property (
    @(posedge clk) disable iff (!rstn)
    count_q <= 2'(DEPTH)
  );

endmodule

//--- verilog/dma_shared_sram.sv
`timescale 1ns/1ns
`include "cgra_dma_consts.svh"

module dma_shared_sram (
  input  logic                  clk,
  input  dma_mem_pkg::mem_req_t apb_req_i,
  output dma_mem_pkg::mem_rsp_t apb_rsp_o,
  input  dma_mem_pkg::mem_req_t tx_req_i,
  output dma_mem_pkg::mem_rsp_t tx_rsp_o,
  input  dma_mem_pkg::mem_req_t rx_req_i,
  output dma_mem_pkg::mem_rsp_t rx_rsp_o
);

  dma_mem_pkg::word_t mem_q [`DMA_MEM_DEPTH];
  logic               apb_gnt;
  logic               tx_gnt;
  logic               rx_gnt;

  // --------------------
  // Fixed priority APB, TX, RX
  // --------------------
  assign apb_gnt = apb_req_i.req;
  assign tx_gnt  = tx_req_i.req & ~apb_req_i.req;
  assign rx_gnt  = rx_req_i.req & ~apb_req_i.req & ~tx_req_i.req;

  // Read data is the pre-write contents of this cycle
  assign apb_rsp_o.gnt   = apb_gnt;
  assign apb_rsp_o.rdata = mem_q[apb_req_i.addr];
  assign tx_rsp_o.gnt    = tx_gnt;
  assign tx_rsp_o.rdata  = mem_q[tx_req_i.addr];
  assign rx_rsp_o.gnt    = rx_gnt;
  assign rx_rsp_o.rdata  = mem_q[rx_req_i.addr];

  // Commit only the granted writer
  always_ff @(posedge clk) begin
    if (apb_gnt && apb_req_i.we) begin
      mem_q[apb_req_i.addr] <= apb_req_i.wdata;
    end else if (tx_gnt && tx_req_i.we) begin
      mem_q[tx_req_i.addr] <= tx_req_i.wdata;
    end else if (rx_gnt && rx_req_i.we) begin
      mem_q[rx_req_i.addr] <= rx_req_i.wdata;
    end
  end

  a_one_grant: assert property (
    @(posedge clk)
    $onehot0({apb_gnt, tx_gnt, rx_gnt})
  );

endmodule

//--- verilog/cgra_dma_top.sv
`timescale 1ns/1ns

module cgra_dma_top (
  input  logic                   clk,
  input  logic                   rstn,
  input  dma_ctrl_pkg::apb_req_t apb_i,
  output dma_ctrl_pkg::apb_rsp_t apb_o
);

  dma_ctrl_pkg::dma_cfg_t  cfg;
  dma_ctrl_pkg::dma_stat_t stat;
  dma_mem_pkg::mem_req_t   apb_mem_req;
  dma_mem_pkg::mem_rsp_t   apb_mem_rsp;
  dma_mem_pkg::mem_req_t   rx_mem_req;
  dma_mem_pkg::mem_rsp_t   rx_mem_rsp;
  dma_mem_pkg::mem_req_t   tx_mem_req;
  dma_mem_pkg::mem_rsp_t   tx_mem_rsp;
  // Ingress is RX to loopback, egress is loopback to TX
  dma_mem_pkg::pkt_t       ing_pkt;
  logic                    ing_valid;
  logic                    ing_ready;
  dma_mem_pkg::pkt_t       egr_pkt;
  logic                    egr_valid;
  logic                    egr_ready;

  dma_reg_decode u_decode (
    .clk    (clk),
    .rstn   (rstn),
    .apb_i  (apb_i),
    .apb_o  (apb_o),
    .cfg_o  (cfg),
    .stat_i (stat),
    .mem_o  (apb_mem_req),
    .mem_i  (apb_mem_rsp)
  );

  dma_rx_engine u_rx (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (cfg.start_rx),
    .src_i       (cfg.src),
    .len_i       (cfg.len_rx),
    .busy_o      (stat.busy_rx),
    .done_o      (stat.done_rx),
    .mem_o       (rx_mem_req),
    .mem_i       (rx_mem_rsp),
    .pkt_o       (ing_pkt),
    .pkt_valid_o (ing_valid),
    .pkt_ready_i (ing_ready)
  );

  dma_tx_engine u_tx (
    .clk         (clk),
    .rstn        (rstn),
    .start_i     (cfg.start_tx),
    .dst_i       (cfg.dst),
    .len_i       (cfg.len_tx),
    .busy_o      (stat.busy_tx),
    .done_o      (stat.done_tx),
    .pkt_i       (egr_pkt),
    .pkt_valid_i (egr_valid),
    .pkt_ready_o (egr_ready),
    .mem_o       (tx_mem_req),
    .mem_i       (tx_mem_rsp)
  );

  // Stand-in for the accelerator
  pkt_loopback_buffer u_loop (
    .clk         (clk),
    .rstn        (rstn),
    .in_i        (ing_pkt),
    .in_valid_i  (ing_valid),
    .in_ready_o  (ing_ready),
    .out_o       (egr_pkt),
    .out_valid_o (egr_valid),
    .out_ready_i (egr_ready)
  );

  dma_shared_sram u_sram (
    .clk       (clk),
    .apb_req_i (apb_mem_req),
    .apb_rsp_o (apb_mem_rsp),
    .tx_req_i  (tx_mem_req),
    .tx_rsp_o  (tx_mem_rsp),
    .rx_req_i  (rx_mem_req),
    .rx_rsp_o  (rx_mem_rsp)
  );

endmodule

//--- verif/cgra_dma_checker.sv
`timescale 1ns/1ns

module cgra_dma_checker (
  input  logic                   clk,
  input  logic                   rstn,
  input  dma_ctrl_pkg::apb_req_t apb_req_i,
  input  dma_ctrl_pkg::apb_rsp_t apb_rsp_i,
  input  logic                   exp_valid_i,
  input  logic [8*16-1:0]        exp_name_i,
  input  int                     exp_idx_i,
  input  dma_mem_pkg::word_t     exp_data_i,
  input  logic                   exp_err_i,
  output int                     pass_cnt_o,
  output int                     fail_cnt_o
);

  int    pass_cnt = 0;
  int    fail_cnt = 0;
  string label;
  logic  done_access;

  // Last cycle of an APB transfer
  assign done_access = apb_req_i.psel & apb_req_i.penable & apb_rsp_i.pready;

  // Indexed names for the per-word checks
  function automatic string test_label(input logic [8*16-1:0] name, input int idx);
    if (idx < 0) begin
      return $sformatf("%0s", name);
    end
    return $sformatf("%0s[%0d]", name, idx);
  endfunction

  // --------------------
  // Compare on flagged accesses
  // --------------------
  // Sampled at the edge that ends the access, before the bus is released
  always @(posedge clk) begin
    if (rstn && exp_valid_i && done_access) begin
      label = test_label(exp_name_i, exp_idx_i);
      if (apb_rsp_i.pslverr !== exp_err_i) begin
        $display("Fail %0s pslverr expected %0b actual %0b",
                 label, exp_err_i, apb_rsp_i.pslverr);
        fail_cnt++;
      end else if (!apb_req_i.pwrite && (apb_rsp_i.prdata !== exp_data_i)) begin
        $display("Fail %0s expected 0x%016h actual 0x%016h",
                 label, exp_data_i, apb_rsp_i.prdata);
        fail_cnt++;
      end else begin
        $display("Pass %0s", label);
        pass_cnt++;
      end
    end
  end

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;

endmodule

//--- verif/cgra_dma_tb.sv
`timescale 1ns/1ns
`include "cgra_dma_consts.svh"

module cgra_dma_tb;

  localparam int CLK_HALF   = 20;
  localparam int RST_CYCLES = 10;
  localparam int RDY_MAX    = 16;
  localparam int POLL_MAX   = 200;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_POLL, OP_IDLE} op_e;

  // One step of the stimulus table
  typedef struct packed {
    op_e                  op;
    logic [8*16-1:0]      name;
    int                   idx;
    dma_ctrl_pkg::paddr_t addr;
    dma_mem_pkg::word_t   wdata;
    dma_mem_pkg::word_t   exp;
    logic                 chk;
    logic                 err;
  } entry_t;

  logic                   clk;
  logic                   rstn;
  dma_ctrl_pkg::apb_req_t apb_req;
  dma_ctrl_pkg::apb_rsp_t apb_rsp;
  logic                   exp_valid;
  logic [8*16-1:0]        exp_name;
  int                     exp_idx;
  dma_mem_pkg::word_t     exp_data;
  logic                   exp_err;
  int                     pass_cnt;
  int                     fail_cnt;
  entry_t                 steps[$];

  cgra_dma_top cgra_dma_top_inst (
    .clk   (clk),
    .rstn  (rstn),
    .apb_i (apb_req),
    .apb_o (apb_rsp)
  );

  cgra_dma_checker u_checker (
    .clk         (clk),
    .rstn        (rstn),
    .apb_req_i   (apb_req),
    .apb_rsp_i   (apb_rsp),
    .exp_valid_i (exp_valid),
    .exp_name_i  (exp_name),
    .exp_idx_i   (exp_idx),
    .exp_data_i  (exp_data),
    .exp_err_i   (exp_err),
    .pass_cnt_o  (pass_cnt),
    .fail_cnt_o  (fail_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // Byte address of an SRAM word in the APB window
  function automatic dma_ctrl_pkg::paddr_t sram_addr(input dma_mem_pkg::waddr_t w);
    return dma_ctrl_pkg::paddr_t'(`DMA_SRAM_BASE) + {1'b0, w, 3'b000};
  endfunction

  task automatic add_entry(input op_e op, input logic [8*16-1:0] name, input int idx,
                           input dma_ctrl_pkg::paddr_t addr, input dma_mem_pkg::word_t wdata,
                           input dma_mem_pkg::word_t exp, input logic chk, input logic err);
    entry_t e;
    e.op    = op;
    e.name  = name;
    e.idx   = idx;
    e.addr  = addr;
    e.wdata = wdata;
    e.exp   = exp;
    e.chk   = chk;
    e.err   = err;
    steps.push_back(e);
  endtask

  task automatic add_write(input logic [8*16-1:0] name, input int idx,
                           input dma_ctrl_pkg::paddr_t addr, input dma_mem_pkg::word_t data);
    add_entry(OP_WR, name, idx, addr, data, '0, 1'b0, 1'b0);
  endtask

  task automatic add_read(input logic [8*16-1:0] name, input int idx,
                          input dma_ctrl_pkg::paddr_t addr, input dma_mem_pkg::word_t exp);
    add_entry(OP_RD, name, idx, addr, '0, exp, 1'b1, 1'b0);
  endtask

  // --------------------
  // Stimulus table
  // --------------------
  task automatic build_table();
    dma_mem_pkg::word_t words [12];
    // Reset values
    add_read("rst_status", -1, `DMA_REG_STATUS, 64'h0);
    add_read("rst_src", -1, `DMA_REG_SRC, 64'h0);
    add_read("rst_dst", -1, `DMA_REG_DST, 64'h0);
    add_read("rst_len_rx", -1, `DMA_REG_LEN_RX, 64'h0);
    add_read("rst_len_tx", -1, `DMA_REG_LEN_TX, 64'h0);
    // Readback truncated to 8-bit addresses and 16-bit lengths
    add_write("reg_src", -1, `DMA_REG_SRC, 64'h1234_5678_9abc_de10);
    add_read("reg_src", -1, `DMA_REG_SRC, 64'h10);
    add_write("reg_dst", -1, `DMA_REG_DST, 64'hffff_ffff_ffff_ff40);
    add_read("reg_dst", -1, `DMA_REG_DST, 64'h40);
    add_write("reg_len_rx", -1, `DMA_REG_LEN_RX, 64'h0000_0000_abcd_0004);
    add_read("reg_len_rx", -1, `DMA_REG_LEN_RX, 64'h4);
    add_write("reg_len_tx", -1, `DMA_REG_LEN_TX, 64'h0000_0007_0000_0004);
    add_read("reg_len_tx", -1, `DMA_REG_LEN_TX, 64'h4);
    add_read("reg_ctrl", -1, `DMA_REG_CTRL, 64'h0);
    // Hole between the registers and the window
    add_entry(OP_RD, "unmapped_rd", -1, 12'h030, '0, '0, 1'b1, 1'b1);
    add_entry(OP_WR, "unmapped_wr", -1, 12'h100, 64'hdead_beef, '0, 1'b1, 1'b1);
    // SRAM window, both ends of the upper region
    words[0] = {$urandom, $urandom};
    words[1] = {$urandom, $urandom};
    add_write("sram_win", 0, sram_addr(8'hf0), words[0]);
    add_write("sram_win", 1, sram_addr(8'hff), words[1]);
    add_read("sram_win", 0, sram_addr(8'hf0), words[0]);
    add_read("sram_win", 1, sram_addr(8'hff), words[1]);
    // Zero length leaves DST alone, done bits still clear from reset
    for (int i = 0; i < 3; i++) begin
      words[i] = {$urandom, $urandom};
      add_write("zl_keep", i, sram_addr(dma_mem_pkg::waddr_t'(8'hc0 + i)), words[i]);
    end
    add_write("zl_dst_reg", -1, `DMA_REG_DST, 64'hc0);
    add_write("zl_len_rx", -1, `DMA_REG_LEN_RX, 64'h0);
    add_write("zl_len_tx", -1, `DMA_REG_LEN_TX, 64'h0);
    add_write("zl_start", -1, `DMA_REG_CTRL, 64'h3);
    add_entry(OP_POLL, "zl_status", -1, `DMA_REG_STATUS, '0, 64'ha, 1'b1, 1'b0);
    for (int i = 0; i < 3; i++) begin
      add_read("zl_keep", i, sram_addr(dma_mem_pkg::waddr_t'(8'hc0 + i)), words[i]);
    end
    // Loopback of 4 packets, SRC 0x10 to DST 0x40
    for (int i = 0; i < 12; i++) begin
      words[i] = {$urandom, $urandom};
      add_write("lb_src", i, sram_addr(dma_mem_pkg::waddr_t'(8'h10 + i)), words[i]);
    end
    add_write("lb_src_reg", -1, `DMA_REG_SRC, 64'h10);
    add_write("lb_dst_reg", -1, `DMA_REG_DST, 64'h40);
    add_write("lb_len_rx", -1, `DMA_REG_LEN_RX, 64'h4);
    add_write("lb_len_tx", -1, `DMA_REG_LEN_TX, 64'h4);
    add_write("lb_start", -1, `DMA_REG_CTRL, 64'h3);
    add_entry(OP_POLL, "lb_status", -1, `DMA_REG_STATUS, '0, 64'ha, 1'b1, 1'b0);
    for (int i = 0; i < 12; i++) begin
      add_read("lb_dst", i, sram_addr(dma_mem_pkg::waddr_t'(8'h40 + i)), words[i]);
    end
    // Back-pressure, 3 packets with TX idle
    for (int i = 0; i < 9; i++) begin
      words[i] = {$urandom, $urandom};
      add_write("bp_src", i, sram_addr(dma_mem_pkg::waddr_t'(8'h80 + i)), words[i]);
    end
    add_write("bp_src_reg", -1, `DMA_REG_SRC, 64'h80);
    add_write("bp_dst_reg", -1, `DMA_REG_DST, 64'ha0);
    add_write("bp_len_rx", -1, `DMA_REG_LEN_RX, 64'h3);
    add_write("bp_len_tx", -1, `DMA_REG_LEN_TX, 64'h3);
    add_write("bp_start_rx", -1, `DMA_REG_CTRL, 64'h1);
    add_entry(OP_IDLE, "bp_wait", -1, '0, 64'd40, '0, 1'b0, 1'b0);
    // Third packet stuck in offer, done_tx still set from the loopback run
    add_read("bp_stall", -1, `DMA_REG_STATUS, 64'h9);
    add_write("bp_start_tx", -1, `DMA_REG_CTRL, 64'h2);
    add_entry(OP_POLL, "bp_status", -1, `DMA_REG_STATUS, '0, 64'ha, 1'b1, 1'b0);
    for (int i = 0; i < 9; i++) begin
      add_read("bp_dst", i, sram_addr(dma_mem_pkg::waddr_t'(8'ha0 + i)), words[i]);
    end
  endtask

  // --------------------
  // APB master
  // --------------------
  task automatic apb_transfer(input entry_t e, input logic checked,
                              output dma_mem_pkg::word_t rdata, output logic ok);
    int waited;
    waited = 0;
    ok     = 1'b0;
    // Setup phase
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= (e.op == OP_WR);
    apb_req.paddr   <= e.addr;
    apb_req.pwdata  <= e.wdata;
    exp_valid       <= checked;
    exp_name        <= e.name;
    exp_idx         <= e.idx;
    exp_data        <= e.exp;
    exp_err         <= e.err;
    // Access phase until pready
    @(posedge clk);
    apb_req.penable <= 1'b1;
    do begin
      @(posedge clk);
      waited++;
      ok = apb_rsp.pready;
    end while (!ok && (waited < RDY_MAX));
    rdata = apb_rsp.prdata;
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    exp_valid       <= 1'b0;
  endtask

  initial begin
    entry_t             e;
    dma_mem_pkg::word_t rdata;
    logic               ok;
    logic               timed_out;
    int                 n;
    int                 polls;
    void'($urandom(61));
    rstn      = 1'b0;
    apb_req   = '0;
    exp_valid = 1'b0;
    exp_name  = '0;
    exp_idx   = -1;
    exp_data  = '0;
    exp_err   = 1'b0;
    timed_out = 1'b0;
    build_table();
    repeat (RST_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    n = 0;
    while ((n < steps.size()) && !timed_out) begin
      e  = steps[n];
      ok = 1'b1;
      case (e.op)
        OP_IDLE: begin
          repeat (int'(e.wdata[15:0])) @(posedge clk);
        end
        OP_POLL: begin
          polls = 0;
          rdata = ~e.exp;
          while ((rdata != e.exp) && (polls < POLL_MAX) && ok) begin
            apb_transfer(e, 1'b0, rdata, ok);
            polls++;
          end
          // One checked read once the value is there
          if (ok && (rdata != e.exp)) begin
            $display("Timed out polling %0s, register stayed at 0x%0h", e.name, rdata);
            timed_out = 1'b1;
          end else if (ok) begin
            apb_transfer(e, 1'b1, rdata, ok);
          end
        end
        default: begin
          apb_transfer(e, e.chk, rdata, ok);
        end
      endcase
      if (!ok) begin
        $display("Timed out waiting for pready on %0s", e.name);
        timed_out = 1'b1;
      end
      n++;
    end
    repeat (2) @(posedge clk);
    $display("Checks: %0d passed, %0d failed, %0d timed out", pass_cnt, fail_cnt, timed_out);
    if ((fail_cnt == 0) && !timed_out) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- cgra_dma.f
+incdir+verilog
verilog/dma_mem_pkg.sv
verilog/dma_ctrl_pkg.sv
verilog/dma_reg_decode.sv
verilog/dma_rx_engine.sv
verilog/dma_tx_engine.sv
verilog/pkt_loopback_buffer.sv
verilog/dma_shared_sram.sv
verilog/cgra_dma_top.sv
verif/cgra_dma_checker.sv
verif/cgra_dma_tb.sv

//--- Makefile
# Verilator build and run of the packet DMA testbench
# Any variable can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= cgra_dma_tb
FILELIST  ?= cgra_dma.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test completed successfully" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
